//--- verilog/mpf_lite_pkg.sv
// Shared widths and payload types for the mpf_lite read shim
// Every RTL module that carries requests or responses imports this package
// The four structs cover the AFU side and the FIU side of the pipeline

package mpf_lite_pkg;

    // Line address width, on both the virtual and the physical side
    localparam int MPF_ADDR_W = 32;

    // One read response carries a single beat of this width
    localparam int MPF_DATA_W = 64;

    // Opaque AFU metadata that is returned untouched with the response
    localparam int MPF_USER_W = 8;

    // Reorder slot index sent to memory as the tag
    // Limits the number of reorder slots to 16
    localparam int MPF_TAG_W = 4;

    // Read request as the AFU issues it
    typedef struct packed {
        logic [MPF_ADDR_W-1:0] addr;
        logic [MPF_USER_W-1:0] user;
    } mpf_afu_req_t;

    // Read request toward memory, with the user field swapped for a tag
    typedef struct packed {
        logic [MPF_ADDR_W-1:0] addr;
        logic [MPF_TAG_W-1:0]  tag;
    } mpf_fiu_req_t;

    // Read response from memory, possibly out of request order
    typedef struct packed {
        logic [MPF_DATA_W-1:0] data;
        logic [MPF_TAG_W-1:0]  tag;
    } mpf_fiu_rsp_t;

    // Read response toward the AFU, always in request order
    typedef struct packed {
        logic [MPF_DATA_W-1:0] data;
        logic [MPF_USER_W-1:0] user;
    } mpf_afu_rsp_t;

endpackage

//--- verilog/mpf_credit_fifo.sv
// Credit-managed FIFO used between the stages of the read shim
// The sender spends one credit per write and starts with DEPTH credits
// The FIFO returns one credit pulse for every entry popped at its head
// The payload type is a parameter so one module buffers any struct

module mpf_credit_fifo
  #(
    parameter int DEPTH = 4,
    parameter type payload_t = logic [7:0]
    )
   (
    input  logic     clk,
    input  logic     rst_n,

    // Write side, credit based
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_credit,

    // Read side, the consumer pops the head when it takes it
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_pop
    );

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Head is visible the cycle after it was written, since count is registered
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    // Storage array
    // The sender never writes without a credit, so a write never hits a full FIFO
    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Pointers, occupancy and the credit return
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end
        else
        begin
            if (in_valid)
            begin
                // Wrap explicitly so DEPTH need not be a power of two
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end

            if (out_pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end

            count <= count + CNT_W'(in_valid) - CNT_W'(out_pop);

            // One freed entry is one credit, sent in the cycle after the pop
            in_credit <= out_pop;
        end
    end

endmodule

//--- verilog/mpf_edge_afu.sv
// AFU edge of the read shim
// Accepts AFU read requests into a small in-order staging buffer and
// forwards them to the request FIFO whenever a FIFO credit is held.
// On the way out each line address is rebased by mem_base, a stand-in
// for address translation. Each forwarded request returns a credit to
// the AFU, which starts with EDGE_SLOTS credits.

module mpf_edge_afu
    import mpf_lite_pkg::*;
  #(
    parameter int EDGE_SLOTS = 2,
    parameter int REQ_FIFO_DEPTH = 4
    )
   (
    input  logic                  clk,
    input  logic                  rst_n,

    // AFU request port, credit based
    input  logic                  afu_req_valid,
    input  mpf_afu_req_t          afu_req,
    output logic                  afu_req_credit,

    // Base added to every virtual line address
    input  logic [MPF_ADDR_W-1:0] mem_base,

    // Toward the request FIFO
    output logic                  req_valid,
    output mpf_afu_req_t          req,
    input  logic                  req_credit
    );

    localparam int PTR_W = (EDGE_SLOTS > 1) ? $clog2(EDGE_SLOTS) : 1;
    localparam int CNT_W = $clog2(EDGE_SLOTS + 1);
    localparam int CRD_W = $clog2(REQ_FIFO_DEPTH + 1);

    mpf_afu_req_t     stage [EDGE_SLOTS];
    logic [PTR_W-1:0] st_wr_ptr;
    logic [PTR_W-1:0] st_rd_ptr;
    logic [CNT_W-1:0] st_count;
    logic [CRD_W-1:0] req_credits;
    logic             send;

    // ========================================================================
    // Staging buffer
    // ========================================================================

    // The AFU only writes while it holds a credit, so no full check here
    always_ff @(posedge clk)
    begin
        if (afu_req_valid)
        begin
            stage[st_wr_ptr] <= afu_req;
        end
    end

    // ========================================================================
    // Forwarding and address rebase
    // ========================================================================

    // Oldest staged request leaves as soon as a request FIFO credit exists
    assign send      = (st_count != '0) && (req_credits != '0);
    assign req_valid = send;

    always_comb
    begin
        req = stage[st_rd_ptr];
        // Modulo 2^32 by truncation to the address width
        req.addr = stage[st_rd_ptr].addr + mem_base;
    end

    // ========================================================================
    // Control state and credit accounting
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            st_wr_ptr      <= '0;
            st_rd_ptr      <= '0;
            st_count       <= '0;
            req_credits    <= CRD_W'(REQ_FIFO_DEPTH);
            afu_req_credit <= 1'b0;
        end
        else
        begin
            if (afu_req_valid)
            begin
                st_wr_ptr <= (st_wr_ptr == PTR_W'(EDGE_SLOTS - 1)) ? '0 : st_wr_ptr + 1'b1;
            end

            if (send)
            begin
                st_rd_ptr <= (st_rd_ptr == PTR_W'(EDGE_SLOTS - 1)) ? '0 : st_rd_ptr + 1'b1;
            end

            st_count <= st_count + CNT_W'(afu_req_valid) - CNT_W'(send);

            // Spend one credit per forwarded request, regain one per FIFO pop
            req_credits <= req_credits + CRD_W'(req_credit) - CRD_W'(send);

            // The freed staging slot goes back to the AFU one cycle later
            afu_req_credit <= send;
        end
    end

endmodule

//--- verilog/mpf_rsp_order.sv
// Response ordering stage of the read shim
// Pops requests from the request FIFO, allocates a reorder slot for each
// and sends it to memory tagged with the slot index. Memory may answer in
// any order; responses land in their slots and leave toward the AFU strictly
// in allocation order, one per cycle, with the AFU user field restored.
// The AFU response link has no back-pressure.

module mpf_rsp_order
    import mpf_lite_pkg::*;
  #(
    parameter int MAX_ACTIVE_REQS = 8,
    parameter int FIU_CREDITS = 4
    )
   (
    input  logic         clk,
    input  logic         rst_n,

    // Head of the request FIFO
    input  logic         req_valid,
    input  mpf_afu_req_t req,
    output logic         req_pop,

    // Memory request port, credit based
    output logic         fiu_req_valid,
    output mpf_fiu_req_t fiu_req,
    input  logic         fiu_req_credit,

    // Head of the response FIFO
    input  logic         rsp_valid,
    input  mpf_fiu_rsp_t rsp,
    output logic         rsp_pop,

    // In-order responses to the AFU
    output logic         afu_rsp_valid,
    output mpf_afu_rsp_t afu_rsp
    );

    localparam int SLOT_W = (MAX_ACTIVE_REQS > 1) ? $clog2(MAX_ACTIVE_REQS) : 1;
    localparam int ACT_W  = $clog2(MAX_ACTIVE_REQS + 1);
    localparam int CRD_W  = $clog2(FIU_CREDITS + 1);

    // Reorder slot contents, no reset needed since filled guards them
    logic [MPF_USER_W-1:0]      slot_user [MAX_ACTIVE_REQS];
    logic [MPF_DATA_W-1:0]      slot_data [MAX_ACTIVE_REQS];
    logic [MAX_ACTIVE_REQS-1:0] slot_filled;

    logic [SLOT_W-1:0]          head;
    logic [SLOT_W-1:0]          tail;
    logic [ACT_W-1:0]           active_cnt;
    logic [CRD_W-1:0]           fiu_credits;
    logic [SLOT_W-1:0]          rsp_slot;
    logic                       issue;
    logic                       emit;

    // ========================================================================
    // Request side
    // ========================================================================

    // A request needs a free slot and a memory credit before it is popped
    assign issue   = req_valid &&
                     (active_cnt < ACT_W'(MAX_ACTIVE_REQS)) &&
                     (fiu_credits != '0);
    assign req_pop = issue;

    // ========================================================================
    // Response side
    // ========================================================================

    // Every response has a slot waiting for it, so the FIFO head is always taken
    assign rsp_pop  = rsp_valid;
    assign rsp_slot = rsp.tag[SLOT_W-1:0];

    // Oldest slot leaves once its data has arrived
    assign emit = slot_filled[head];

    // ========================================================================
    // Slot storage and output payloads
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            slot_user[tail] <= req.user;
            fiu_req.addr    <= req.addr;
            fiu_req.tag     <= MPF_TAG_W'(tail);
        end

        if (rsp_valid)
        begin
            slot_data[rsp_slot] <= rsp.data;
        end

        if (emit)
        begin
            afu_rsp.data <= slot_data[head];
            afu_rsp.user <= slot_user[head];
        end
    end

    // ========================================================================
    // Slot allocation, credits and valids
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            slot_filled   <= '0;
            head          <= '0;
            tail          <= '0;
            active_cnt    <= '0;
            fiu_credits   <= CRD_W'(FIU_CREDITS);
            fiu_req_valid <= 1'b0;
            afu_rsp_valid <= 1'b0;
        end
        else
        begin
            // A filling slot is never the head being emitted, the head is already full
            if (rsp_valid)
            begin
                slot_filled[rsp_slot] <= 1'b1;
            end

            if (emit)
            begin
                slot_filled[head] <= 1'b0;
                head <= (head == SLOT_W'(MAX_ACTIVE_REQS - 1)) ? '0 : head + 1'b1;
            end

            if (issue)
            begin
                tail <= (tail == SLOT_W'(MAX_ACTIVE_REQS - 1)) ? '0 : tail + 1'b1;
            end

            active_cnt <= active_cnt + ACT_W'(issue) - ACT_W'(emit);

            // The credit is spent at the pop, the request goes out a cycle later
            fiu_credits   <= fiu_credits + CRD_W'(fiu_req_credit) - CRD_W'(issue);
            fiu_req_valid <= issue;
            afu_rsp_valid <= emit;
        end
    end

endmodule

//--- verilog/mpf_pipe_std.sv
// Top level of the mpf_lite read shim
// Chains the AFU edge, the request FIFO, the response ordering stage and
// the response FIFO. The AFU connects on the afu_* ports and memory on the
// fiu_* ports; every link except the AFU response uses credits.

module mpf_pipe_std
    import mpf_lite_pkg::*;
  #(
    parameter int EDGE_SLOTS = 2,
    parameter int REQ_FIFO_DEPTH = 4,
    parameter int RSP_FIFO_DEPTH = 4,
    parameter int MAX_ACTIVE_REQS = 8,
    parameter int FIU_CREDITS = 4
    )
   (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [MPF_ADDR_W-1:0] mem_base,

    // AFU side
    input  logic                  afu_req_valid,
    input  mpf_afu_req_t          afu_req,
    output logic                  afu_req_credit,
    output logic                  afu_rsp_valid,
    output mpf_afu_rsp_t          afu_rsp,

    // Memory side
    output logic                  fiu_req_valid,
    output mpf_fiu_req_t          fiu_req,
    input  logic                  fiu_req_credit,
    input  logic                  fiu_rsp_valid,
    input  mpf_fiu_rsp_t          fiu_rsp,
    output logic                  fiu_rsp_credit
    );

    logic         edge_req_valid;
    mpf_afu_req_t edge_req;
    logic         edge_req_credit;
    logic         ord_req_valid;
    mpf_afu_req_t ord_req;
    logic         ord_req_pop;
    logic         ord_rsp_valid;
    mpf_fiu_rsp_t ord_rsp;
    logic         ord_rsp_pop;

    // ========================================================================
    // AFU edge, staging and address rebase
    // ========================================================================

    mpf_edge_afu #(.EDGE_SLOTS(EDGE_SLOTS), .REQ_FIFO_DEPTH(REQ_FIFO_DEPTH)) edge_afu (
        .clk, .rst_n, .afu_req_valid, .afu_req, .afu_req_credit, .mem_base,
        .req_valid(edge_req_valid), .req(edge_req), .req_credit(edge_req_credit));

    // ========================================================================
    // Request buffer between the edge and the ordering stage
    // ========================================================================

    mpf_credit_fifo #(.DEPTH(REQ_FIFO_DEPTH), .payload_t(mpf_afu_req_t)) req_fifo (
        .clk, .rst_n,
        .in_valid(edge_req_valid), .in_data(edge_req), .in_credit(edge_req_credit),
        .out_valid(ord_req_valid), .out_data(ord_req), .out_pop(ord_req_pop));

    // ========================================================================
    // Response buffer on the memory side
    // ========================================================================

    // Memory starts with RSP_FIFO_DEPTH credits toward this buffer
    mpf_credit_fifo #(.DEPTH(RSP_FIFO_DEPTH), .payload_t(mpf_fiu_rsp_t)) rsp_fifo (
        .clk, .rst_n,
        .in_valid(fiu_rsp_valid), .in_data(fiu_rsp), .in_credit(fiu_rsp_credit),
        .out_valid(ord_rsp_valid), .out_data(ord_rsp), .out_pop(ord_rsp_pop));

    // ========================================================================
    // Tagging, issue to memory and in-order response release
    // ========================================================================

    mpf_rsp_order #(.MAX_ACTIVE_REQS(MAX_ACTIVE_REQS), .FIU_CREDITS(FIU_CREDITS)) rsp_order (
        .clk, .rst_n,
        .req_valid(ord_req_valid), .req(ord_req), .req_pop(ord_req_pop),
        .fiu_req_valid, .fiu_req, .fiu_req_credit,
        .rsp_valid(ord_rsp_valid), .rsp(ord_rsp), .rsp_pop(ord_rsp_pop),
        .afu_rsp_valid, .afu_rsp);

endmodule

//--- test/mpf_mem_model.sv
// Behavioral memory for the mpf_lite testbench
// Takes tagged line reads, holds each for a random delay of up to max_delay
// cycles and answers them in any order while it holds response FIFO credits.
// Every answered request frees one request credit back toward the DUT.

module mpf_mem_model
    import mpf_lite_pkg::*;
  #(
    parameter int FIU_CREDITS = 4,
    parameter int RSP_FIFO_DEPTH = 4
    )
   (
    input  logic         clk,
    input  logic         rst_n,
    input  int           max_delay,
    input  logic         fiu_req_valid,
    input  mpf_fiu_req_t fiu_req,
    output logic         fiu_req_credit,
    output logic         fiu_rsp_valid,
    output mpf_fiu_rsp_t fiu_rsp,
    input  logic         fiu_rsp_credit,
    output logic         overflow
    );

    mpf_fiu_req_t pend_req [FIU_CREDITS];
    int           pend_delay [FIU_CREDITS];
    logic         pend_busy [FIU_CREDITS];
    int           rsp_credits;

    // Line contents are a fixed mix of the physical line address
    function automatic logic [MPF_DATA_W-1:0] line_data(input logic [MPF_ADDR_W-1:0] a);
        return {a ^ 32'hC3A5_5A3C, {a[15:0], a[31:16]} + 32'h1357_9BDF};
    endfunction

    // Outputs change on the falling edge, the DUT samples them on the rising one
    always @(negedge clk or negedge rst_n)
    begin : mem_proc
        int pick;
        int start;
        int idx;
        bit stored;
        if (!rst_n)
        begin
            fiu_req_credit = 1'b0;
            fiu_rsp_valid  = 1'b0;
            fiu_rsp        = '0;
            overflow       = 1'b0;
            rsp_credits    = RSP_FIFO_DEPTH;
            for (int i = 0; i < FIU_CREDITS; i++)
            begin
                pend_busy[i] = 1'b0;
            end
        end
        else
        begin
            fiu_req_credit = 1'b0;
            fiu_rsp_valid  = 1'b0;
            if (fiu_rsp_credit)
            begin
                rsp_credits++;
            end
            for (int i = 0; i < FIU_CREDITS; i++)
            begin
                if (pend_busy[i] && pend_delay[i] > 0)
                begin
                    pend_delay[i]--;
                end
            end
            // Park a new request in any free entry
            if (fiu_req_valid)
            begin
                stored = 1'b0;
                for (int i = 0; i < FIU_CREDITS; i++)
                begin
                    if (!stored && !pend_busy[i])
                    begin
                        pend_busy[i]  = 1'b1;
                        pend_req[i]   = fiu_req;
                        pend_delay[i] = 1 + ($urandom % max_delay);
                        stored        = 1'b1;
                    end
                end
                if (!stored)
                begin
                    overflow = 1'b1;
                end
            end
            // A random starting point scrambles the answer order
            pick  = -1;
            start = $urandom % FIU_CREDITS;
            for (int k = 0; k < FIU_CREDITS; k++)
            begin
                idx = (start + k) % FIU_CREDITS;
                if (pick < 0 && pend_busy[idx] && pend_delay[idx] == 0)
                begin
                    pick = idx;
                end
            end
            if (pick >= 0 && rsp_credits > 0)
            begin
                rsp_credits--;
                pend_busy[pick] = 1'b0;
                fiu_rsp.data    = line_data(pend_req[pick].addr);
                fiu_rsp.tag     = pend_req[pick].tag;
                fiu_rsp_valid   = 1'b1;
                fiu_req_credit  = 1'b1;
            end
        end
    end

endmodule

//--- test/mpf_pipe_std_asserts.sv
// Concurrent checks bound into the FIFOs and the response ordering stage
// Ports are generic: a push and pop on a counted store, a credit spend with
// its returned credit, and a slot fill against a vector of filled flags.

module mpf_pipe_std_asserts
  #(
    parameter int DEPTH = 4,
    parameter int CREDITS = 1
    )
   (
    input logic        clk,
    input logic        rst_n,
    input logic        push,
    input logic        pop,
    input logic [7:0]  level,
    input logic        spend,
    input logic        refund,
    input logic        fill,
    input logic [7:0]  fill_idx,
    input logic [15:0] filled
    );

    // Requests sent that the receiver has not yet answered with a credit
    int in_flight;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            in_flight <= 0;
        end
        else
        begin
            in_flight <= in_flight + int'(spend) - int'(refund);
        end
    end

    // A write must find a free entry
    push_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (level < DEPTH))
        else $error("write into a full store");

    // A pop must find an occupied entry
    pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> (level != 0))
        else $error("pop from an empty store");

    // Memory requests go out only while the receiver still has room
    spend_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
        spend |-> (in_flight < CREDITS))
        else $error("memory request issued with no credit");

    // Each reorder slot receives at most one response
    fill_once: assert property (@(posedge clk) disable iff (!rst_n)
        fill |-> !filled[fill_idx[3:0]])
        else $error("reorder slot filled twice");

endmodule

bind mpf_credit_fifo mpf_pipe_std_asserts #(.DEPTH(DEPTH)) fifo_asserts (
    .clk(clk), .rst_n(rst_n), .push(in_valid), .pop(out_pop), .level(8'(count)),
    .spend(1'b0), .refund(1'b0), .fill(1'b0), .fill_idx(8'd0), .filled(16'd0));

bind mpf_rsp_order mpf_pipe_std_asserts
    #(.DEPTH(MAX_ACTIVE_REQS), .CREDITS(FIU_CREDITS)) order_asserts (
    .clk(clk), .rst_n(rst_n), .push(1'b0), .pop(emit), .level(8'(active_cnt)),
    .spend(fiu_req_valid), .refund(fiu_req_credit), .fill(rsp_valid),
    .fill_idx(8'(rsp_slot)), .filled(16'(slot_filled)));

//--- test/mpf_pipe_std_tb.sv
// Testbench for the mpf_lite read shim
// Drives AFU reads on falling edges against a tracked credit count and
// checks that responses come back in request order with the expected data.

module mpf_pipe_std_tb;
    import mpf_lite_pkg::*;

    localparam int EDGE_SLOTS = 2;
    localparam int REQ_FIFO_DEPTH = 4;
    localparam int RSP_FIFO_DEPTH = 4;
    localparam int MAX_ACTIVE_REQS = 8;
    localparam int FIU_CREDITS = 4;
    localparam int TIMEOUT = 5000;

    logic clk, rst_n, afu_req_valid, afu_req_credit, afu_rsp_valid;
    logic fiu_req_valid, fiu_req_credit, fiu_rsp_valid, fiu_rsp_credit, overflow;
    logic [MPF_ADDR_W-1:0] mem_base;
    mpf_afu_req_t afu_req;
    mpf_afu_rsp_t afu_rsp;
    mpf_fiu_req_t fiu_req;
    mpf_fiu_rsp_t fiu_rsp;
    int max_delay;

    int afu_credits = EDGE_SLOTS;
    int value_errs = 0;
    int other_errs = 0;
    int req_count = 0;
    int rsp_count = 0;
    int stall_cycles = 0;
    int ooo_rsps = 0;
    logic [MPF_DATA_W-1:0] exp_data [$];
    logic [MPF_USER_W-1:0] exp_user [$];
    logic [MPF_TAG_W-1:0]  open_tags [$];

    mpf_pipe_std #(.EDGE_SLOTS(EDGE_SLOTS), .REQ_FIFO_DEPTH(REQ_FIFO_DEPTH),
                   .RSP_FIFO_DEPTH(RSP_FIFO_DEPTH), .MAX_ACTIVE_REQS(MAX_ACTIVE_REQS),
                   .FIU_CREDITS(FIU_CREDITS)) mpf_pipe_std_inst (.*);

    mpf_mem_model #(.FIU_CREDITS(FIU_CREDITS), .RSP_FIFO_DEPTH(RSP_FIFO_DEPTH)) mem_model (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Expected line data, a mix of the rebased address taken modulo 2^32
    function automatic logic [MPF_DATA_W-1:0] expected_data(input logic [31:0] addr,
                                                            input logic [31:0] base);
        logic [31:0] phys;
        phys = addr + base;
        return {phys ^ 32'hC3A5_5A3C, {phys[15:0], phys[31:16]} + 32'h1357_9BDF};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("errors: %0d value, %0d other", value_errs, other_errs + 1);
        $display("TB FAILED");
        $finish;
    endtask

    // Returned AFU credits arrive as one-cycle pulses
    always @(negedge clk)
    begin
        if (rst_n && afu_req_credit)
        begin
            afu_credits++;
        end
    end

    // Memory tags in issue order, to see answers overtake older requests
    always @(posedge clk)
    begin : tag_track
        int idx;
        idx = -1;
        if (rst_n && fiu_req_valid)
        begin
            open_tags.push_back(fiu_req.tag);
        end
        if (rst_n && fiu_rsp_valid)
        begin
            for (int i = 0; i < open_tags.size(); i++)
            begin
                if (idx < 0 && open_tags[i] == fiu_rsp.tag)
                begin
                    idx = i;
                end
            end
            // An answer that is not for the oldest open request came early
            if (idx > 0)
            begin
                ooo_rsps++;
            end
            if (idx >= 0)
            begin
                open_tags.delete(idx);
            end
        end
    end

    // Compare each response with the oldest outstanding request
    always @(negedge clk)
    begin
        if (rst_n && afu_rsp_valid)
        begin
            rsp_count++;
            if (exp_data.size() == 0)
            begin
                $display("Response arrived with no request outstanding");
                other_errs++;
            end
            else
            begin
                if (afu_rsp.data !== exp_data[0])
                begin
                    $display("CHECK FAILED afu_rsp.data: got %h expected %h",
                             afu_rsp.data, exp_data[0]);
                    value_errs++;
                end
                if (afu_rsp.user !== exp_user[0])
                begin
                    $display("CHECK FAILED afu_rsp.user: got %h expected %h",
                             afu_rsp.user, exp_user[0]);
                    value_errs++;
                end
                void'(exp_data.pop_front());
                void'(exp_user.pop_front());
            end
        end
    end

    // Send one read, stalling on falling edges while no credit is held
    task automatic send_req(input logic [31:0] addr, input logic [7:0] user);
        int waited;
        waited = 0;
        @(negedge clk);
        afu_req_valid = 1'b0;
        while (afu_credits == 0)
        begin
            if (waited > TIMEOUT)
            begin
                abort_run("Timed out waiting for an AFU request credit");
            end
            waited++;
            stall_cycles++;
            @(negedge clk);
        end
        afu_credits--;
        afu_req_valid = 1'b1;
        afu_req.addr  = addr;
        afu_req.user  = user;
        exp_data.push_back(expected_data(addr, mem_base));
        exp_user.push_back(user);
        req_count++;
    endtask

    // Close the last valid pulse, then wait for all responses and credits
    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clk);
        afu_req_valid = 1'b0;
        while (exp_data.size() != 0 || afu_credits != EDGE_SLOTS)
        begin
            if (waited > TIMEOUT)
            begin
                abort_run("Timed out waiting for outstanding responses to drain");
            end
            waited++;
            @(negedge clk);
        end
    endtask

    task automatic check_idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            if (afu_rsp_valid || fiu_req_valid || afu_req_credit || fiu_rsp_credit)
            begin
                $display("CHECK FAILED idle outputs: rsp %h req %h afu_crd %h rsp_crd %h",
                         afu_rsp_valid, fiu_req_valid, afu_req_credit, fiu_rsp_credit);
                value_errs++;
            end
        end
    endtask

    initial
    begin
        void'($urandom(32'h4874_5986));
        rst_n = 1'b0;
        afu_req_valid = 1'b0;
        afu_req = '0;
        mem_base = '0;
        max_delay = 4;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_idle(10);

        // Single read with no rebase
        send_req(32'h0000_1000, 8'h5A);
        drain();

        // Random burst, memory answers out of order
        repeat (40) send_req($urandom, 8'($urandom));
        drain();
        if (stall_cycles == 0)
        begin
            $display("Driver never ran out of AFU credits during the burst");
            other_errs++;
        end
        if (ooo_rsps == 0)
        begin
            $display("Memory never answered out of order during the burst");
            other_errs++;
        end

        // Rebased addresses, several of them wrap past 2^32
        mem_base = 32'hFFFF_FF00;
        send_req(32'hFFFF_FFF0, 8'h11);
        send_req(32'h0000_0100, 8'h22);
        repeat (20) send_req($urandom, 8'($urandom));
        drain();

        // Slow memory holds credits back through the whole chain
        max_delay = 80;
        repeat (20) send_req($urandom, 8'($urandom));
        drain();

        if (overflow)
        begin
            $display("Memory received a request beyond its credit limit");
            other_errs++;
        end
        if (rsp_count != req_count)
        begin
            $display("CHECK FAILED rsp_count: got %h expected %h", rsp_count, req_count);
            value_errs++;
        end
        $display("errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- mpf_lite.f
verilog/mpf_lite_pkg.sv
verilog/mpf_credit_fifo.sv
verilog/mpf_edge_afu.sv
verilog/mpf_rsp_order.sv
verilog/mpf_pipe_std.sv
test/mpf_mem_model.sv
test/mpf_pipe_std_asserts.sv
test/mpf_pipe_std_tb.sv
